//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_shared_mem -f vlog.f -o sim_shared_mem
./obj_dir/sim_shared_mem

//--- src/bank_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "shmem_cfg.svh"

module bank_arbiter
(
	input	wire				clk,
	input	wire				reset,
	input	wire	[`BANK_ID_W-1:0]	bank_id,
	input	wire	shmem_req_pkg::core_req_t	req	[`NUM_CORES],
	input	wire				hold,
	input	wire				dump_rd,
	input	wire	[`WORD_ID_W-1:0]	dump_word,
	output	shmem_req_pkg::bank_cmd_t	cmd,
	output	logic				grant
);

	import shmem_req_pkg::*;

	logic	[`NUM_CORES-1:0]	mask;
	logic	[`CORE_ID_W-1:0]	last;
	logic	[`CORE_ID_W-1:0]	pick;
	logic				found;

	// only live requests aimed at this bank compete, and none while held
	always_comb
	begin
		for (int c = 0; c < `NUM_CORES; c++)
			mask[c] = !hold && (req[c].op inside {OP_READ, OP_WRITE})
				&& (req[c].bank == bank_id);
	end

	rr_core_picker u_picker
	(
		.mask	(mask),
		.start	(last),
		.found	(found),
		.core	(pick)
	);

	assign grant = found && !dump_rd;

	// highest core counts as last granted so that core 0 goes first
	always_ff @(posedge clk)
	begin
		if (reset)
			last <= `CORE_ID_W'(`NUM_CORES - 1);
		else if (grant)
			last <= pick;
	end

	always_comb
	begin
		cmd = '0;
		if (dump_rd)
		begin
			cmd.rd = 1'b1;	// the walk takes the bank over
			cmd.word = dump_word;
		end
		else if (found)
		begin
			cmd.rd = (req[pick].op == OP_READ);
			cmd.wr = (req[pick].op == OP_WRITE);
			cmd.word = req[pick].word;
			cmd.wdata = req[pick].wdata;
			cmd.core = pick;
		end
	end

endmodule

`default_nettype wire

//--- src/dump_addr_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "shmem_cfg.svh"

module dump_addr_counter
(
	input	wire				clk,
	input	wire				reset,
	input	wire				en,
	output	logic	[`BANK_ID_W-1:0]	bank,
	output	logic	[`WORD_ID_W-1:0]	word,
	output	logic				last
);

	logic	word_wrap;
	logic	bank_wrap;

	assign word_wrap = (word == `WORD_ID_W'(`BANK_DEPTH - 1));
	assign bank_wrap = (bank == `BANK_ID_W'(`NUM_BANKS - 1));

	// word is the fast index, so the walk is bank-major
	always_ff @(posedge clk)
	begin
		if (reset || !en)
		begin
			bank <= '0;
			word <= '0;
		end
		else if (word_wrap)
		begin
			word <= '0;
			bank <= bank_wrap ? '0 : bank + 1'b1;
		end
		else
		begin
			word <= word + 1'b1;
		end
	end

	assign last = en && word_wrap && bank_wrap;

endmodule

`default_nettype wire

//--- src/dump_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "shmem_cfg.svh"

module dump_ctrl
(
	input	wire	clk,
	input	wire	reset,
	input	wire	dump,
	input	wire	last,
	output	logic	count_en,
	output	logic	busy,
	output	logic	valid
);

	import shmem_dump_pkg::*;

	dump_state_t	state;
	dump_state_t	state_next;

	// a pulse outside idle falls through the case and is ignored
	always_comb
	begin
		state_next = state;
		case (state)
			DUMP_IDLE:
				if (dump)
					state_next = DUMP_READ;
			DUMP_READ:
				if (last)
					state_next = DUMP_DRAIN;
			DUMP_DRAIN:
				state_next = DUMP_IDLE;
			default:
				state_next = DUMP_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= DUMP_IDLE;
			valid <= 1'b0;
		end
		else
		begin
			state <= state_next;
			valid <= count_en;	// bank data lands one cycle after the read strobe
		end
	end

	assign count_en = (state == DUMP_READ);
	assign busy = (state != DUMP_IDLE);

endmodule

`default_nettype wire

//--- src/mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "shmem_cfg.svh"

module mem_bank
(
	input	wire				clk,
	input	wire				reset,
	input	wire	shmem_req_pkg::bank_cmd_t	cmd,
	output	logic	[`WORD_W-1:0]		rdata
);

	logic	[`WORD_W-1:0]	mem	[`BANK_DEPTH];

	// the whole bank is zeroed on the reset edge
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `BANK_DEPTH; i++)
				mem[i] <= '0;
		end
		else if (cmd.wr)
		begin
			mem[cmd.word] <= cmd.wdata;
		end
	end

	// read data stays put between read strobes
	always_ff @(posedge clk)
	begin
		if (cmd.rd)
			rdata <= mem[cmd.word];
	end

endmodule

`default_nettype wire

//--- src/rr_core_picker.sv
`timescale 1ns/1ps
`default_nettype none

`include "shmem_cfg.svh"

module rr_core_picker
(
	input	wire	[`NUM_CORES-1:0]	mask,
	input	wire	[`CORE_ID_W-1:0]	start,
	output	logic				found,
	output	logic	[`CORE_ID_W-1:0]	core
);

	// circular scan beginning one past start, so start itself is checked last
	always_comb
	begin
		int idx;

		found = 1'b0;
		core = '0;
		for (int i = 1; i <= `NUM_CORES; i++)
		begin
			idx = (int'(start) + i) % `NUM_CORES;
			if (!found && mask[idx])
			begin
				found = 1'b1;
				core = `CORE_ID_W'(idx);
			end
		end
	end

endmodule

`default_nettype wire

//--- src/shared_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "shmem_cfg.svh"

module shared_mem
(
	input	wire				clk,
	input	wire				reset,
	input	wire	shmem_req_pkg::core_req_t	req	[`NUM_CORES],
	output	logic	[`NUM_CORES-1:0]	ready,
	output	logic	[`WORD_W-1:0]		rdata	[`NUM_CORES],
	input	wire				dump,
	output	logic				dump_valid,
	output	shmem_dump_pkg::dump_beat_t	dump_beat,
	output	logic				dump_busy
);

	import shmem_req_pkg::*;

	core_req_t			req_live	[`NUM_CORES];
	bank_cmd_t			bank_cmd	[`NUM_BANKS];
	logic	[`NUM_BANKS-1:0]	bank_grant;
	logic	[`WORD_W-1:0]		bank_rdata	[`NUM_BANKS];
	logic	[`NUM_CORES-1:0]	wr_gnt;
	logic	[`NUM_CORES-1:0]	rd_gnt;
	logic	[`BANK_ID_W-1:0]	rd_src		[`NUM_CORES];
	logic	[`NUM_CORES-1:0]	rd_pend;
	logic	[`BANK_ID_W-1:0]	rd_bank		[`NUM_CORES];
	logic				hold;
	logic				count_en;
	logic				dump_last;
	logic	[`BANK_ID_W-1:0]	dump_bank;
	logic	[`WORD_ID_W-1:0]	dump_word;
	logic	[`BANK_ID_W-1:0]	beat_bank;
	logic	[`WORD_ID_W-1:0]	beat_word;

	// the pulse cycle is held too, so no read answer overlaps the walk
	assign hold = dump_busy || dump;

	// a read being answered is still held by its core and must not win a second time
	always_comb
	begin
		for (int c = 0; c < `NUM_CORES; c++)
		begin
			req_live[c] = req[c];
			if (rd_pend[c])
				req_live[c].op = OP_NONE;
		end
	end

	genvar b;
	generate for (b = 0; b < `NUM_BANKS; b++)
	begin: g_bank
		bank_arbiter u_arbiter
		(
			.clk		(clk),
			.reset		(reset),
			.bank_id	(`BANK_ID_W'(b)),
			.req		(req_live),
			.hold		(hold),
			.dump_rd	(count_en && (dump_bank == `BANK_ID_W'(b))),
			.dump_word	(dump_word),
			.cmd		(bank_cmd[b]),
			.grant		(bank_grant[b])
		);

		mem_bank u_bank
		(
			.clk	(clk),
			.reset	(reset),
			.cmd	(bank_cmd[b]),
			.rdata	(bank_rdata[b])
		);
	end
	endgenerate

	// a core is granted in at most one bank, since it has a single request
	always_comb
	begin
		for (int c = 0; c < `NUM_CORES; c++)
		begin
			wr_gnt[c] = 1'b0;
			rd_gnt[c] = 1'b0;
			rd_src[c] = '0;
			for (int k = 0; k < `NUM_BANKS; k++)
			begin
				if (bank_grant[k] && (bank_cmd[k].core == `CORE_ID_W'(c)))
				begin
					wr_gnt[c] = wr_gnt[c] || bank_cmd[k].wr;
					rd_gnt[c] = rd_gnt[c] || bank_cmd[k].rd;
					rd_src[c] = `BANK_ID_W'(k);
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			rd_pend <= '0;
		else
			rd_pend <= rd_gnt;
	end

	always_ff @(posedge clk)
	begin
		for (int c = 0; c < `NUM_CORES; c++)
			if (rd_gnt[c])
				rd_bank[c] <= rd_src[c];
	end

	always_comb
	begin
		for (int c = 0; c < `NUM_CORES; c++)
			rdata[c] = rd_pend[c] ? bank_rdata[rd_bank[c]] : '0;
	end

	assign ready = wr_gnt | rd_pend;	// writes answer at once, reads a cycle later

	dump_ctrl u_dump_ctrl
	(
		.clk		(clk),
		.reset		(reset),
		.dump		(dump),
		.last		(dump_last),
		.count_en	(count_en),
		.busy		(dump_busy),
		.valid		(dump_valid)
	);

	dump_addr_counter u_dump_counter
	(
		.clk	(clk),
		.reset	(reset),
		.en	(count_en),
		.bank	(dump_bank),
		.word	(dump_word),
		.last	(dump_last)
	);

	// position follows the bank read data by one cycle
	always_ff @(posedge clk)
	begin
		if (count_en)
		begin
			beat_bank <= dump_bank;
			beat_word <= dump_word;
		end
	end

	assign dump_beat.bank = beat_bank;
	assign dump_beat.word = beat_word;
	assign dump_beat.data = bank_rdata[beat_bank];

endmodule

`default_nettype wire

//--- src/shmem_cfg.svh
`ifndef SHMEM_CFG_SVH
`define SHMEM_CFG_SVH

// sizes of the shared memory
`define NUM_CORES	4
`define NUM_BANKS	4
`define WORD_W		16
`define BANK_DEPTH	16

// index widths derived from the sizes above
`define CORE_ID_W	2
`define BANK_ID_W	2
`define WORD_ID_W	4

`endif

//--- src/shmem_dump_pkg.sv
`default_nettype none

`include "shmem_cfg.svh"

package shmem_dump_pkg;

	typedef enum logic [1:0]
	{
		DUMP_IDLE  = 2'd0,
		DUMP_READ  = 2'd1,
		DUMP_DRAIN = 2'd2	// waits for the last registered read
	} dump_state_t;

	// one streamed word of the memory walk
	typedef struct packed
	{
		logic [`BANK_ID_W-1:0]	bank;
		logic [`WORD_ID_W-1:0]	word;
		logic [`WORD_W-1:0]	data;
	} dump_beat_t;

endpackage

`default_nettype wire

//--- src/shmem_req_pkg.sv
`default_nettype none

`include "shmem_cfg.svh"

package shmem_req_pkg;

	typedef enum logic [1:0]
	{
		OP_NONE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2
	} op_t;

	// one core's request as it arrives at the top
	typedef struct packed
	{
		op_t			op;
		logic [`BANK_ID_W-1:0]	bank;	// top address bits select the bank
		logic [`WORD_ID_W-1:0]	word;
		logic [`WORD_W-1:0]	wdata;
	} core_req_t;

	// what a single bank executes in one cycle
	typedef struct packed
	{
		logic			rd;
		logic			wr;
		logic [`WORD_ID_W-1:0]	word;
		logic [`WORD_W-1:0]	wdata;
		logic [`CORE_ID_W-1:0]	core;	// winner of the bank, zero on dump reads
	} bank_cmd_t;

endpackage

`default_nettype wire

//--- tests/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

	logic	[`WORD_W-1:0]		model_mem	[`NUM_BANKS][`BANK_DEPTH];
	int				rr_last		[`NUM_BANKS];	// last core served by each bank
	logic	[`NUM_CORES-1:0]	model_pend;	// reads granted one cycle ago
	logic	[`WORD_W-1:0]		model_rdata	[`NUM_CORES];
	int				busy_left;
	logic	[`NUM_CORES-1:0]	exp_ready;
	logic	[`WORD_W-1:0]		exp_rdata	[`NUM_CORES];
	logic				exp_busy;
	logic				exp_valid;

	task automatic model_reset();
		foreach (model_mem[b, w])
			model_mem[b][w] = '0;
		foreach (rr_last[b])
			rr_last[b] = `NUM_CORES - 1;	// core 0 is served first after reset
		foreach (model_rdata[c])
			model_rdata[c] = '0;
		model_pend = '0;
		busy_left = 0;
	endtask

	// next requesting core after the last one served, or -1 if the bank is not asked
	function automatic int next_winner(input int bank);
		int c;

		c = rr_last[bank];
		for (int n = 0; n < `NUM_CORES; n++)
		begin
			c = (c + 1) % `NUM_CORES;
			if (!model_pend[c] && req[c].op != OP_NONE && int'(req[c].bank) == bank)
				return c;	// a core waiting for its read answer does not compete
		end
		return -1;
	endfunction

	// steps the memory by one clock while the inputs are stable
	task automatic model_cycle();
		logic	[`NUM_CORES-1:0]	rd_next;
		logic				hold;
		int				win;

		exp_busy = (busy_left > 0);
		exp_valid = exp_busy && (busy_left <= `NUM_BANKS * `BANK_DEPTH);
		exp_ready = model_pend;
		foreach (exp_rdata[c])
			exp_rdata[c] = model_pend[c] ? model_rdata[c] : '0;
		hold = exp_busy || dump;	// the pulse cycle already blocks grants
		rd_next = '0;
		for (int b = 0; b < `NUM_BANKS; b++)
		begin
			win = hold ? -1 : next_winner(b);
			if (win >= 0)
			begin
				rr_last[b] = win;
				if (req[win].op == OP_WRITE)
				begin
					exp_ready[win] = 1'b1;
					model_mem[b][req[win].word] = req[win].wdata;
				end
				else
				begin
					rd_next[win] = 1'b1;
					model_rdata[win] = model_mem[b][req[win].word];
				end
			end
		end
		model_pend = rd_next;
		if (busy_left > 0)
			busy_left--;
		else if (dump)
			busy_left = `NUM_BANKS * `BANK_DEPTH + 1;	// walk plus the drain cycle
	endtask

`endif

//--- tests/tb_shared_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "shmem_cfg.svh"

module tb_shared_mem;

	import shmem_req_pkg::*;
	import shmem_dump_pkg::*;

	typedef enum {MODE_FAIR, MODE_PAR, MODE_WRITE, MODE_READ, MODE_MIX} test_mode_t;

	localparam int PHASE_LIMIT = 2000;

	logic				clk = 1'b0;
	logic				reset;
	core_req_t			req		[`NUM_CORES];
	logic	[`NUM_CORES-1:0]	ready;
	logic	[`WORD_W-1:0]		rdata		[`NUM_CORES];
	logic				dump;
	logic				dump_valid;
	dump_beat_t			dump_beat;
	logic				dump_busy;

	logic	[15:0]			lfsr;
	logic	[`NUM_CORES-1:0]	seen_ready;
	int				fair_order	[$];
	bit				fair_on;
	bit				par_on;
	int				beat_idx;
	int				wait_cycles;

	`include "tb_mem_model.svh"

	shared_mem u_shared_mem
	(
		.clk		(clk),
		.reset		(reset),
		.req		(req),
		.ready		(ready),
		.rdata		(rdata),
		.dump		(dump),
		.dump_valid	(dump_valid),
		.dump_beat	(dump_beat),
		.dump_busy	(dump_busy)
	);

	always #20 clk = ~clk;

	task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			$display("TEST FAIL");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic stall(input string what);
		$display("timeout: %s", what);
		$display("TEST FAIL");
		$fatal(1, "stopped on a timeout");
	endtask

	// Fibonacci LFSR with taps 16, 14, 13 and 11 that steps once per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic	[15:0]	val;
		logic		fb;

		val = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			val = {val[14:0], fb};
		end
		return val;
	endfunction

	function automatic core_req_t make_req(input int c, input test_mode_t mode);
		core_req_t	r;
		logic	[15:0]	bits;

		bits = rand_bits(`WORD_ID_W - `CORE_ID_W);
		r.word = {bits[`WORD_ID_W-`CORE_ID_W-1:0], `CORE_ID_W'(c)};	// each core owns its words
		bits = rand_bits(`BANK_ID_W);
		r.bank = bits[`BANK_ID_W-1:0];
		r.wdata = rand_bits(`WORD_W);
		r.op = OP_WRITE;
		case (mode)
			MODE_FAIR:
				r.bank = `BANK_ID_W'(2);
			MODE_PAR:
				r.bank = `BANK_ID_W'(c);
			MODE_READ:
				r.op = OP_READ;
			MODE_MIX:
			begin
				bits = rand_bits(1);
				r.op = bits[0] ? OP_READ : OP_WRITE;
			end
			default:
				r.op = OP_WRITE;
		endcase
		return r;
	endfunction

	// each core issues ops requests and holds every one until it sees ready
	task automatic run_phase(input test_mode_t mode, input int ops, input bit with_dump);
		int			left	[`NUM_CORES];
		logic	[`NUM_CORES-1:0]	active;
		int			cycles;
		bit			more;

		active = '0;
		cycles = 0;
		foreach (left[c])
			left[c] = ops;
		do
		begin
			@(posedge clk);
			more = 1'b0;
			for (int c = 0; c < `NUM_CORES; c++)
			begin
				if (active[c] && seen_ready[c])
					active[c] = 1'b0;
				if (!active[c] && left[c] > 0)
				begin
					req[c] <= make_req(c, mode);
					active[c] = 1'b1;
					left[c]--;
				end
				else if (!active[c])
					req[c] <= '0;
				more = more || active[c];
			end
			dump <= with_dump && (cycles == 0);
			cycles++;
			if (cycles > PHASE_LIMIT)
				stall("a core request was never answered with ready");
		end while (more);
	endtask

	always @(negedge clk)
	begin
		if (!reset)
		begin
			model_cycle();
			check_val(ready, exp_ready, "ready vector of the cores");
			for (int c = 0; c < `NUM_CORES; c++)
				if (ready[c])
					check_val(req[c].op != OP_NONE, 1'b1,
						$sformatf("ready of core %0d without a request", c));
			for (int c = 0; c < `NUM_CORES; c++)
				check_val(rdata[c], exp_rdata[c], $sformatf("rdata of core %0d", c));
			check_val(dump_busy, exp_busy, "dump_busy");
			check_val(dump_valid, exp_valid, "dump_valid");
			if (dump_busy)
				check_val(ready, '0, "ready while the dump runs");
			if (par_on && ready != '0)
				check_val(ready, {`NUM_CORES{1'b1}}, "writes to four banks in one cycle");
			for (int c = 0; c < `NUM_CORES; c++)
				if (fair_on && ready[c])
					fair_order.push_back(c);
			if (dump_valid)
			begin
				check_val(dump_beat.bank, beat_idx / `BANK_DEPTH, "dump beat bank");
				check_val(dump_beat.word, beat_idx % `BANK_DEPTH, "dump beat word");
				check_val(dump_beat.data,
					model_mem[beat_idx / `BANK_DEPTH][beat_idx % `BANK_DEPTH],
					"dump beat data");
				beat_idx++;
			end
			seen_ready = ready;
		end
	end

	initial
	begin
		reset <= 1'b1;
		dump <= 1'b0;
		for (int c = 0; c < `NUM_CORES; c++)
			req[c] <= '0;
		lfsr = 16'd16;
		seen_ready = '0;
		fair_on = 1'b0;
		par_on = 1'b0;
		beat_idx = 0;
		model_reset();
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		fair_on = 1'b1;	// all cores hit bank 2 for two rounds
		run_phase(MODE_FAIR, 2, 1'b0);
		fair_on = 1'b0;
		check_val(fair_order.size(), 2 * `NUM_CORES, "grants in the fairness rounds");
		foreach (fair_order[k])
			check_val(fair_order[k], k % `NUM_CORES, "round-robin grant order");

		par_on = 1'b1;
		run_phase(MODE_PAR, 4, 1'b0);
		par_on = 1'b0;
		run_phase(MODE_WRITE, 12, 1'b0);
		run_phase(MODE_READ, 12, 1'b0);
		run_phase(MODE_MIX, 3, 1'b1);	// requests wait behind the dump

		wait_cycles = 0;
		do
		begin
			@(negedge clk);
			wait_cycles++;
			if (wait_cycles > PHASE_LIMIT)
				stall("dump_busy never fell after the dump pulse");
		end while (dump_busy);
		check_val(beat_idx, `NUM_BANKS * `BANK_DEPTH, "number of dump beats");

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
+incdir+tests
src/shmem_req_pkg.sv
src/shmem_dump_pkg.sv
src/rr_core_picker.sv
src/mem_bank.sv
src/bank_arbiter.sv
src/dump_ctrl.sv
src/dump_addr_counter.sv
src/shared_mem.sv
tests/tb_shared_mem.sv
